//--- dcache_params.svh
/*
  geometry of the data cache: 8 sets, 2 ways, 2 words per block
  the address split in dcache_pkg assumes these values add up to DC_WORD_W
  (tag + idx + 1 block offset bit + byte offset)
  changing DC_WAYS alone is not enough, the lookup compare is built for 2 ways
*/
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_WORD_W      32 // data and address width
`define DC_SETS        8
`define DC_IDX_W       3
`define DC_WAYS        2
`define DC_TAG_W       26
`define DC_BYTE_OFF_W  2

`endif

//--- dcache_pkg.sv
/*
  shared types of the data cache
  daddr_t must stay exactly DC_WORD_W wide, it is cast to and from word_t
  state encoding is 4 bits, enough for the sequencer only
*/
`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]      tag;
        logic [`DC_IDX_W-1:0]      idx;
        logic                      blkoff;  // word within the block
        logic [`DC_BYTE_OFF_W-1:0] byteoff;
    } daddr_t;

    typedef logic [1:0][`DC_WORD_W-1:0] line_t;

    typedef line_t [`DC_WAYS-1:0] data_set_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } meta_t;

    typedef meta_t [`DC_WAYS-1:0] meta_set_t;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        FILL1,
        FILL2,
        FLUSH_SCAN,
        FLUSH_W1,
        FLUSH_W2,
        DONE
    } seq_state_t;

endpackage

//--- set_array.sv
/*
  per-set storage, one entry per set index
  read is combinational, write lands on the rising edge
  a read of the index being written returns the old entry in that cycle
  all entries clear on reset so valid and dirty bits start low
*/
`timescale 1ns/1ps
`include "dcache_params.svh"

module set_array
    import dcache_pkg::*;
#(
    parameter type entry_t = meta_set_t
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [`DC_IDX_W-1:0] rd_idx,
    output entry_t               rd_entry,
    input  logic                 wr_en,
    input  logic [`DC_IDX_W-1:0] wr_idx,
    input  entry_t               wr_entry
);

    entry_t mem [`DC_SETS];

    assign rd_entry = mem[rd_idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `DC_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

endmodule

//--- lookup.sv
/*
  tag compare and load mux for the 2-way data cache
  meta and data must be the set selected by addr.idx, only then is hit
  meaningful; hit is forced low when no request is present
  one LRU bit per set names the victim way, it moves on every hitting cycle
  so a request held for several cycles refreshes the same way each time
*/
`timescale 1ns/1ps
`include "dcache_params.svh"

module lookup
    import dcache_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  daddr_t    addr,
    input  logic      req,
    input  meta_set_t meta,
    input  data_set_t data,
    output logic      hit,
    output logic      hit_way,
    output logic      victim_way,
    output word_t     dmemload
);

    logic [`DC_WAYS-1:0] way_hit;
    logic [`DC_SETS-1:0] lru; // 1 means way 1 is the victim

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = meta[w].valid && (meta[w].tag == addr.tag);
        end
    end

    assign hit        = req && (|way_hit);
    assign hit_way    = way_hit[1];           // way 1 wins if both match
    assign victim_way = lru[addr.idx];
    assign dmemload   = data[hit_way][addr.blkoff];

    // the way just used becomes the most recent one
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (hit) begin
            lru[addr.idx] <= ~hit_way;
        end
    end

endmodule

//--- mem_sequencer.sv
/*
  miss, writeback, fill and flush control of the data cache
  the datapath must hold addr, dmemren, dmemwen and dmemstore until dhit
  memory side moves one word per edge with dren or dwen high and dwait low;
  address and data are held stable while dwait is high
  halt is taken in IDLE only when no request is pending; after the flush the
  sequencer parks in DONE until reset, so later requests are not served
  only dirty blocks are written back during the flush
*/
`timescale 1ns/1ps
`include "dcache_params.svh"

module mem_sequencer
    import dcache_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  daddr_t               addr,
    input  logic                 dmemren,
    input  logic                 dmemwen,
    input  logic                 halt,
    input  word_t                dmemstore,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  meta_set_t            meta,
    input  data_set_t            data,
    output logic [`DC_IDX_W-1:0] rd_idx,
    output logic                 meta_wr_en,
    output logic                 data_wr_en,
    output logic [`DC_IDX_W-1:0] wr_idx,
    output meta_set_t            meta_wr,
    output data_set_t            data_wr,
    output logic                 dren,
    output logic                 dwen,
    output word_t                daddr,
    output word_t                dstore,
    input  word_t                dload,
    input  logic                 dwait,
    output logic                 flushed
);

    seq_state_t state, next_state;

    logic [`DC_IDX_W-1:0] flush_idx;
    logic                 flush_way;
    logic                 flush_adv;
    logic                 flush_last;
    logic                 flushing;
    logic                 word_sel;
    logic                 req;
    daddr_t               bus_addr;
    meta_t                vmeta;
    meta_t                fmeta;

    assign req        = dmemren | dmemwen;
    assign flushing   = (state == FLUSH_SCAN) || (state == FLUSH_W1) || (state == FLUSH_W2);
    assign word_sel   = (state == WB2) || (state == FILL2) || (state == FLUSH_W2);
    assign flush_last = (flush_idx == `DC_IDX_W'(`DC_SETS - 1)) && flush_way;
    assign vmeta      = meta[victim_way];
    assign fmeta      = meta[flush_way];

    // flush walks the sets with its own index, everything else uses the request
    assign rd_idx = flushing ? flush_idx : addr.idx;
    assign wr_idx = rd_idx;
    assign daddr  = bus_addr;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_idx <= '0;
            flush_way <= 1'b0;
            flushed   <= 1'b0;
        end else begin
            state <= next_state;
            if (flush_adv) begin
                flush_way <= ~flush_way;
                if (flush_way) begin
                    flush_idx <= flush_idx + 1'b1;
                end
            end
            if (state == DONE) begin
                flushed <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        dren       = 1'b0;
        dwen       = 1'b0;
        bus_addr   = '0;
        dstore     = '0;
        meta_wr    = meta;
        data_wr    = data;
        meta_wr_en = 1'b0;
        data_wr_en = 1'b0;
        flush_adv  = 1'b0;

        case (state)
            IDLE: begin
                if (req && hit) begin
                    if (dmemwen) begin
                        data_wr[hit_way][addr.blkoff] = dmemstore;
                        meta_wr[hit_way].dirty         = 1'b1;
                        data_wr_en                     = 1'b1;
                        meta_wr_en                     = 1'b1;
                    end
                end else if (req) begin
                    next_state = (vmeta.valid && vmeta.dirty) ? WB1 : FILL1;
                end else if (halt) begin
                    next_state = FLUSH_SCAN;
                end
            end

            WB1, WB2: begin
                dwen     = 1'b1;
                bus_addr = '{tag: vmeta.tag, idx: addr.idx, blkoff: word_sel, byteoff: '0};
                dstore   = data[victim_way][word_sel];
                if (!dwait) begin
                    if (state == WB2) begin
                        meta_wr[victim_way].dirty = 1'b0;
                        meta_wr_en                = 1'b1;
                        next_state                = FILL1;
                    end else begin
                        next_state = WB2;
                    end
                end
            end

            FILL1, FILL2: begin
                dren     = 1'b1;
                bus_addr = '{tag: addr.tag, idx: addr.idx, blkoff: word_sel, byteoff: '0};
                if (!dwait) begin
                    // a store to this word replaces the memory copy
                    data_wr[victim_way][word_sel] =
                        (dmemwen && (addr.blkoff == word_sel)) ? dmemstore : dload;
                    data_wr_en = 1'b1;
                    meta_wr_en = 1'b1;
                    if (state == FILL1) begin
                        meta_wr[victim_way].valid = 1'b0; // no hit on a half-filled block
                        meta_wr[victim_way].dirty = 1'b0;
                        next_state                = FILL2;
                    end else begin
                        meta_wr[victim_way] = '{valid: 1'b1, dirty: dmemwen, tag: addr.tag};
                        next_state          = IDLE;
                    end
                end
            end

            FLUSH_SCAN: begin
                if (fmeta.valid && fmeta.dirty) begin
                    next_state = FLUSH_W1;
                end else begin
                    flush_adv  = 1'b1;
                    next_state = flush_last ? DONE : FLUSH_SCAN;
                end
            end

            FLUSH_W1, FLUSH_W2: begin
                dwen     = 1'b1;
                bus_addr = '{tag: fmeta.tag, idx: flush_idx, blkoff: word_sel, byteoff: '0};
                dstore   = data[flush_way][word_sel];
                if (!dwait) begin
                    if (state == FLUSH_W2) begin
                        meta_wr[flush_way].valid = 1'b0;
                        meta_wr[flush_way].dirty = 1'b0;
                        meta_wr_en               = 1'b1;
                        flush_adv                = 1'b1;
                        next_state               = flush_last ? DONE : FLUSH_SCAN;
                    end else begin
                        next_state = FLUSH_W2;
                    end
                end
            end

            DONE: begin
                next_state = DONE; // parked until reset
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

//--- dcache.sv
/*
  2-way set associative data cache, 8 sets, 2 words per block
  write-back, write-allocate, LRU per set
  dhit is combinational and valid while the request is held
  memory side uses a dwait handshake, one word per accepted cycle
*/
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    // datapath side
    input  logic  dmemren,
    input  logic  dmemwen,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output logic  dhit,
    output word_t dmemload,
    input  logic  halt,
    output logic  flushed,
    // memory side
    output logic  dren,
    output logic  dwen,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);

    daddr_t               req_addr;
    logic                 req;
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic [`DC_IDX_W-1:0] rd_idx;
    logic [`DC_IDX_W-1:0] wr_idx;
    logic                 meta_wr_en;
    logic                 data_wr_en;
    meta_set_t            meta_rd;
    meta_set_t            meta_wr;
    data_set_t            data_rd;
    data_set_t            data_wr;

    assign req_addr = daddr_t'(dmemaddr);
    assign req      = dmemren | dmemwen;
    assign dhit     = hit;

    set_array #(.entry_t(meta_set_t)) meta_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_idx   (rd_idx),
        .rd_entry (meta_rd),
        .wr_en    (meta_wr_en),
        .wr_idx   (wr_idx),
        .wr_entry (meta_wr)
    );

    set_array #(.entry_t(data_set_t)) data_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_idx   (rd_idx),
        .rd_entry (data_rd),
        .wr_en    (data_wr_en),
        .wr_idx   (wr_idx),
        .wr_entry (data_wr)
    );

    lookup lookup_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .addr       (req_addr),
        .req        (req),
        .meta       (meta_rd),
        .data       (data_rd),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .dmemload   (dmemload)
    );

    mem_sequencer seq_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .addr       (req_addr),
        .dmemren    (dmemren),
        .dmemwen    (dmemwen),
        .halt       (halt),
        .dmemstore  (dmemstore),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .meta       (meta_rd),
        .data       (data_rd),
        .rd_idx     (rd_idx),
        .meta_wr_en (meta_wr_en),
        .data_wr_en (data_wr_en),
        .wr_idx     (wr_idx),
        .meta_wr    (meta_wr),
        .data_wr    (data_wr),
        .dren       (dren),
        .dwen       (dwen),
        .daddr      (daddr),
        .dstore     (dstore),
        .dload      (dload),
        .dwait      (dwait),
        .flushed    (flushed)
    );

endmodule

//--- dcache_checker.sv
/*
  reference model and scoreboard for the data cache testbench
  assumes each request is held until dhit and dropped on the next falling edge
  reference memory is copied from the memory model on the first edge after reset
  only 64 words are modelled, the word index is addr[7:2]
  victim choice follows one LRU bit per set, way 0 is the victim after reset
*/
`timescale 1ns/1ps

module dcache_checker
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemren,
    input  logic  dmemwen,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  logic  dhit,
    input  word_t dmemload,
    input  logic  flushed,
    input  logic  dren,
    input  logic  dwen,
    input  word_t daddr,
    input  word_t mem_words [64],
    output int    errors,
    output int    checks,
    output logic  flush_checked
);

    word_t       ref_mem [64];
    logic [25:0] ref_tag [8][2];
    logic        ref_valid [8][2];
    logic        ref_dirty [8][2];
    logic        ref_lru [8];
    logic        started;
    logic        pending; // request seen, dhit not yet

    function automatic logic [5:0] word_of(input logic [25:0] tag, input logic [2:0] set,
                                           input logic blk);
        return {tag[1:0], set, blk};
    endfunction

    task automatic compare(input string name, input word_t expected, input word_t actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Error: time %0t, %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_fault(input string what);
        errors = errors + 1;
        $display("failure at time %0t: %s", $time, what);
    endtask

    always @(posedge CLK) begin
        logic [2:0]  set;
        logic [25:0] tag;
        logic        blk;
        logic        way;
        logic        found;
        logic [5:0]  wi;
        if (!nRST) begin
            started       = 1'b0;
            pending       = 1'b0;
            errors        = 0;
            checks        = 0;
            flush_checked = 1'b0;
            for (int s = 0; s < 8; s++) begin
                ref_lru[s] = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    ref_tag[s][w]   = '0;
                    ref_valid[s][w] = 1'b0;
                    ref_dirty[s][w] = 1'b0;
                end
            end
        end else if (!started) begin
            started = 1'b1;
            for (int i = 0; i < 64; i++) begin
                ref_mem[i] = mem_words[i];
            end
        end else begin
            if (dren && dwen) begin
                report_fault("dren and dwen are high together");
            end
            if ((dren || dwen) && daddr[1:0] != 2'b00) begin
                report_fault("daddr has a nonzero byte offset");
            end
            if (flushed && dwen) begin
                report_fault("memory write after flushed");
            end
            if (dmemren || dmemwen) begin
                set   = dmemaddr[5:3];
                tag   = dmemaddr[31:6];
                blk   = dmemaddr[2];
                found = 1'b0;
                way   = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    if (!found && ref_valid[set][w] && ref_tag[set][w] == tag) begin
                        found = 1'b1;
                        way   = 1'(w);
                    end
                end
                if (!pending) begin
                    compare("dhit", {31'b0, found}, {31'b0, dhit}); // first cycle prediction
                    pending = 1'b1;
                end
                if (dhit) begin
                    pending = 1'b0;
                    if (!found) begin
                        way = ref_lru[set];
                        if (ref_valid[set][way] && ref_dirty[set][way]) begin
                            wi = word_of(ref_tag[set][way], set, 1'b0);
                            compare($sformatf("mem[%0d]", wi), ref_mem[wi], mem_words[wi]);
                            wi = word_of(ref_tag[set][way], set, 1'b1);
                            compare($sformatf("mem[%0d]", wi), ref_mem[wi], mem_words[wi]);
                        end
                        ref_tag[set][way]   = tag;
                        ref_valid[set][way] = 1'b1;
                        ref_dirty[set][way] = 1'b0;
                    end
                    wi = word_of(tag, set, blk);
                    if (dmemwen) begin
                        ref_dirty[set][way] = 1'b1;
                        ref_mem[wi]         = dmemstore;
                    end else begin
                        compare("dmemload", ref_mem[wi], dmemload);
                    end
                    ref_lru[set] = ~way;
                end
            end
            if (flushed && !flush_checked) begin
                flush_checked = 1'b1;
                for (int i = 0; i < 64; i++) begin
                    compare($sformatf("mem[%0d]", i), ref_mem[i], mem_words[i]);
                end
            end
        end
    end

endmodule

//--- tb_dcache.sv
/*
  testbench for the data cache, 100 ns clock, reset held for 2 cycles
  stimulus and dwait come from a 16-bit Fibonacci LFSR seeded with 15
  the memory model holds 64 words, so only byte addresses below 0x100 are used
  requests draw 4 tags over sets 2 and 5, which forces evictions in both ways
*/
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int N_DIRECTED = 7;
    localparam int N_RANDOM   = 200;
    localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 12 + 200;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        dmemren;
    logic        dmemwen;
    word_t       dmemaddr;
    word_t       dmemstore;
    logic        dhit;
    word_t       dmemload;
    logic        halt;
    logic        flushed;
    logic        dren;
    logic        dwen;
    word_t       daddr;
    word_t       dstore;
    word_t       dload = '0;
    logic        dwait = 1'b0;

    word_t       mem [64];
    logic [15:0] stim_lfsr;
    logic [15:0] wait_lfsr = 16'd15;
    int          cycles = 0;
    int          requests = 0;
    int          errors;
    int          checks;
    logic        flush_checked;

    always #50 CLK = ~CLK;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t fill_word(input logic [5:0] i);
        return {16'hc0de, 2'b00, i, 2'b00, ~i};
    endfunction

    function automatic word_t make_addr(input logic [1:0] tag, input logic [2:0] set,
                                        input logic blk);
        return {24'h0, tag, set, blk, 2'b00};
    endfunction

    task automatic draw_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    // called on a falling edge, returns on the falling edge after dhit
    task automatic do_request(input logic wr, input word_t addr, input word_t data);
        dmemren   = !wr;
        dmemwen   = wr;
        dmemaddr  = addr;
        dmemstore = wr ? data : '0;
        do begin
            @(posedge CLK);
        end while (!dhit);
        @(negedge CLK);
        dmemren  = 1'b0;
        dmemwen  = 1'b0;
        requests = requests + 1;
    endtask

    task automatic report_test(input string name, input int err_base, input int req_base);
        $display("test %s: %0d requests, %0d errors", name, requests - req_base,
                 errors - err_base);
    endtask

    initial begin
        word_t r;
        word_t d;
        logic  wr;
        int    err_base;
        int    req_base;
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        halt      = 1'b0;
        stim_lfsr = 16'd15;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK); // checker copies memory on the edge in between

        err_base = errors;
        req_base = requests;
        do_request(1'b1, make_addr(2'd0, 3'd2, 1'b1), 32'h1111_aaaa); // fills way 0
        do_request(1'b0, make_addr(2'd0, 3'd2, 1'b1), '0);
        do_request(1'b1, make_addr(2'd1, 3'd2, 1'b0), 32'h2222_bbbb); // fills way 1
        do_request(1'b0, make_addr(2'd1, 3'd2, 1'b0), '0);
        do_request(1'b1, make_addr(2'd2, 3'd2, 1'b1), 32'h3333_cccc); // dirty way 0 out
        do_request(1'b0, make_addr(2'd0, 3'd2, 1'b1), '0);            // dirty way 1 out
        do_request(1'b0, make_addr(2'd2, 3'd2, 1'b1), '0);
        report_test("directed", err_base, req_base);

        err_base = errors;
        req_base = requests;
        for (int n = 0; n < N_RANDOM; n++) begin
            draw_bits(1, r);
            wr = r[0];
            draw_bits(4, r);
            d = '0;
            if (wr) begin
                draw_bits(32, d);
            end
            do_request(wr, make_addr(r[3:2], r[1] ? 3'd5 : 3'd2, r[0]), d);
        end
        report_test("random", err_base, req_base);

        err_base = errors;
        req_base = requests;
        halt = 1'b1;
        while (!flush_checked) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK); // bus has to stay quiet after flushed
        report_test("flush", err_base, req_base);

        $display("summary: %0d requests, %0d checks, %0d errors", requests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    dcache dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .halt      (halt),
        .flushed   (flushed),
        .dren      (dren),
        .dwen      (dwen),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait)
    );

    dcache_checker check_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .dmemren       (dmemren),
        .dmemwen       (dmemwen),
        .dmemaddr      (dmemaddr),
        .dmemstore     (dmemstore),
        .dhit          (dhit),
        .dmemload      (dmemload),
        .flushed       (flushed),
        .dren          (dren),
        .dwen          (dwen),
        .daddr         (daddr),
        .mem_words     (mem),
        .errors        (errors),
        .checks        (checks),
        .flush_checked (flush_checked)
    );

    // memory model moves one word per edge with dwait low
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= fill_word(6'(i));
            end
        end else if (dwen && !dwait) begin
            mem[daddr[7:2]] <= dstore;
        end
    end

    always @(negedge CLK) begin
        wait_lfsr = lfsr_step(lfsr_step(wait_lfsr));
        dwait <= wait_lfsr[1] & wait_lfsr[0]; // about one cycle in four
        dload <= dren ? mem[daddr[7:2]] : '1; // no valid word without a read
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+.
dcache_pkg.sv
set_array.sv
lookup.sv
mem_sequencer.sv
dcache.sv
dcache_checker.sv
tb_dcache.sv

//--- Makefile
# Verilator build and run of the data cache testbench
# override on the command line, e.g. make LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) dcache_params.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
